/* design/revo_pkg.sv */
`default_nettype none

package revo_pkg;

	// buckets carried by one clock50 word
	localparam int WORD_BUCKETS = 8;

	// field widths
	localparam int PERIOD_W = 13;
	localparam int PRESCALE_W = 8;
	localparam int REVOLUTION_COUNT_W = 16;

	// alternating-bit reference clock, bit 0 is the earliest bucket
	localparam logic [WORD_BUCKETS-1:0] CLOCK_PATTERN_0 = 8'hAA;
	localparam logic [WORD_BUCKETS-1:0] CLOCK_PATTERN_1 = 8'h55;

	// power-up hold before the generator starts
	localparam int READY_DELAY = 1024;
	localparam int READY_COUNT_W = $clog2(READY_DELAY);

	// revolution led hold time
	localparam int LED_STRETCH_CYCLES = 4096;
	localparam int STRETCH_COUNT_W = $clog2(LED_STRETCH_CYCLES + 1);

	// heartbeat counter bit on led 0
	localparam int HEARTBEAT_BIT = 22;

	typedef struct packed {
		// revolution length in buckets, 16 to 8191
		logic [PERIOD_W-1:0] period_buckets;
		// revolutions per trigger, 0 disables
		logic [PRESCALE_W-1:0] prescale;
		// 0 selects AA, 1 selects 55
		logic clock_phase;
	} bucket_cfg_t;

	typedef struct packed {
		logic [WORD_BUCKETS-1:0] clock_word;
		logic [WORD_BUCKETS-1:0] revo_word;
		logic [WORD_BUCKETS-1:0] trig_word;
		// OR of revo_word
		logic revo;
	} word_frame_t;

	typedef enum logic {
		idle = 1'b0,
		running = 1'b1
	} sequencer_state_t;

endpackage

`default_nettype wire

/* design/reset_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module reset_sequencer (
	input logic clock50,
	input logic rst_n,
	output logic run,
	output revo_pkg::sequencer_state_t state
);
	import revo_pkg::*;

	// cycles spent in idle since reset release
	logic [READY_COUNT_W-1:0] delay_count;

	always_ff @(posedge clock50) begin
		if (!rst_n) begin
			state <= idle;
			delay_count <= '0;
			run <= 1'b0;
		end else begin
			// run trails the state by one cycle
			run <= (state == running);
			if (state == idle) begin
				// leave idle one cycle early so run lands on READY_DELAY
				if (delay_count == READY_COUNT_W'(READY_DELAY - 1)) begin
					state <= running;
				end else begin
					delay_count <= delay_count + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/bucket_word_generator.sv */
`default_nettype none
`timescale 1ns/1ps

module bucket_word_generator (
	input logic clock50,
	input logic rst_n,
	input logic run,
	input revo_pkg::bucket_cfg_t cfg,
	input logic cfg_load,
	output revo_pkg::bucket_cfg_t active_cfg,
	output revo_pkg::word_frame_t word
);
	import revo_pkg::*;

	// bucket index of bit 0 of the current word
	logic [PERIOD_W-1:0] position;

	// one extra bit so the sum cannot wrap before the compare
	logic [PERIOD_W:0] advanced;
	logic [PERIOD_W-1:0] next_position;

	logic [WORD_BUCKETS-1:0] revo_bits;
	logic [WORD_BUCKETS-1:0] clock_bits;

	// configuration capture
	always_ff @(posedge clock50) begin
		if (!rst_n) begin
			active_cfg <= '0;
		end else if (cfg_load) begin
			active_cfg <= cfg;
		end
	end

	// bucket position within the revolution
	always_ff @(posedge clock50) begin
		if (!rst_n) begin
			position <= '0;
		end else if (cfg_load) begin
			// new config starts at the top of a revolution
			position <= '0;
		end else if (run) begin
			position <= next_position;
		end
	end

	// advance by one word, modulo the period
	always_comb begin
		advanced = {1'b0, position} + (PERIOD_W + 1)'(WORD_BUCKETS);
		if (advanced >= {1'b0, active_cfg.period_buckets}) begin
			// period is at least 16, one subtraction is enough
			next_position = PERIOD_W'(advanced - {1'b0, active_cfg.period_buckets});
		end else begin
			next_position = PERIOD_W'(advanced);
		end
	end

	// marker search over the eight buckets of this word
	always_comb begin
		logic [PERIOD_W:0] bucket_sum;
		revo_bits = '0;
		for (int k = 0; k < WORD_BUCKETS; k++) begin
			bucket_sum = {1'b0, position} + (PERIOD_W + 1)'(k);
			// position stays below the period, so only 0 or period can match
			if (bucket_sum == '0 || bucket_sum == {1'b0, active_cfg.period_buckets}) begin
				revo_bits[k] = 1'b1;
			end
		end
	end

	// reference clock pattern
	always_comb begin
		if (active_cfg.clock_phase) begin
			clock_bits = CLOCK_PATTERN_1;
		end else begin
			clock_bits = CLOCK_PATTERN_0;
		end
	end

	// word stays zero until the sequencer releases the generator
	always_comb begin
		word = '0;
		if (run) begin
			word.clock_word = clock_bits;
			word.revo_word = revo_bits;
			word.revo = |revo_bits;
		end
	end

endmodule

`default_nettype wire

/* design/trigger_prescaler.sv */
`default_nettype none
`timescale 1ns/1ps

module trigger_prescaler (
	input logic clock50,
	input logic rst_n,
	input logic run,
	input revo_pkg::bucket_cfg_t active_cfg,
	input logic cfg_load,
	input revo_pkg::word_frame_t word,
	output revo_pkg::word_frame_t frame,
	output logic [15:0] revolution_count
);
	import revo_pkg::*;

	// revolutions seen since the last load or trigger
	logic [PRESCALE_W-1:0] revo_phase;
	logic marker;
	logic triggers_on;
	logic trigger_hit;
	word_frame_t frame_next;

	assign marker = run && word.revo;
	assign triggers_on = (active_cfg.prescale != '0);

	// first marker after a load is revolution 1
	assign trigger_hit = marker && triggers_on &&
		(PRESCALE_W'(revo_phase + 1'b1) == active_cfg.prescale);

	always_ff @(posedge clock50) begin
		if (!rst_n) begin
			revo_phase <= '0;
		end else if (cfg_load) begin
			revo_phase <= '0;
		end else if (trigger_hit) begin
			revo_phase <= '0;
		end else if (marker && triggers_on) begin
			revo_phase <= revo_phase + 1'b1;
		end
	end

	// copy the marker into the trigger word on the selected revolution
	always_comb begin
		frame_next = word;
		frame_next.trig_word = '0;
		if (trigger_hit) begin
			frame_next.trig_word = word.revo_word;
		end
	end

	// output frame and running total, updated on the same edge
	always_ff @(posedge clock50) begin
		if (!rst_n) begin
			frame <= '0;
			revolution_count <= '0;
		end else begin
			frame <= frame_next;
			if (marker) begin
				revolution_count <= revolution_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/status_leds.sv */
`default_nettype none
`timescale 1ns/1ps

module status_leds (
	input logic clock50,
	input logic rst_n,
	input revo_pkg::sequencer_state_t state,
	input logic revo,
	input logic [7:0] prescale,
	output logic [7:0] led
);
	import revo_pkg::*;

	logic [HEARTBEAT_BIT:0] heartbeat;

	// cycles left on the revolution blink
	logic [STRETCH_COUNT_W-1:0] stretch_count;
	logic [7:0] led_next;

	always_ff @(posedge clock50) begin
		if (!rst_n) begin
			heartbeat <= '0;
		end else begin
			heartbeat <= heartbeat + 1'b1;
		end
	end

	// a marker restarts the hold, otherwise count down to zero
	always_ff @(posedge clock50) begin
		if (!rst_n) begin
			stretch_count <= '0;
		end else if (revo) begin
			stretch_count <= STRETCH_COUNT_W'(LED_STRETCH_CYCLES);
		end else if (stretch_count != '0) begin
			stretch_count <= stretch_count - 1'b1;
		end
	end

	// led map, unused positions stay dark
	always_comb begin
		led_next = '0;
		led_next[7] = (state == running);
		led_next[6] = (prescale != '0);
		led_next[4] = revo || (stretch_count != '0);
		led_next[2] = (state == idle);
		led_next[0] = heartbeat[HEARTBEAT_BIT];
	end

	always_ff @(posedge clock50) begin
		if (!rst_n) begin
			led <= '0;
		end else begin
			led <= led_next;
		end
	end

endmodule

`default_nettype wire

/* design/revo_generator_top.sv */
`default_nettype none
`timescale 1ns/1ps

module revo_generator_top (
	input logic clock50,
	input logic rst_n,
	input revo_pkg::bucket_cfg_t cfg,
	input logic cfg_load,
	output revo_pkg::word_frame_t frame,
	output logic [15:0] revolution_count,
	output logic [7:0] led
);
	import revo_pkg::*;

	logic run;
	sequencer_state_t state;

	// config in use and the unregistered word for this cycle
	bucket_cfg_t active_cfg;
	word_frame_t word;

	// power-up hold
	reset_sequencer reset_sequencer_inst (
		.clock50 (clock50),
		.rst_n   (rst_n),
		.run     (run),
		.state   (state)
	);

	// bucket position and marker placement
	bucket_word_generator bucket_word_generator_inst (
		.clock50    (clock50),
		.rst_n      (rst_n),
		.run        (run),
		.cfg        (cfg),
		.cfg_load   (cfg_load),
		.active_cfg (active_cfg),
		.word       (word)
	);

	// trigger gating and output register
	trigger_prescaler trigger_prescaler_inst (
		.clock50          (clock50),
		.rst_n            (rst_n),
		.run              (run),
		.active_cfg       (active_cfg),
		.cfg_load         (cfg_load),
		.word             (word),
		.frame            (frame),
		.revolution_count (revolution_count)
	);

	// front panel
	status_leds status_leds_inst (
		.clock50  (clock50),
		.rst_n    (rst_n),
		.state    (state),
		.revo     (frame.revo),
		.prescale (active_cfg.prescale),
		.led      (led)
	);

endmodule

`default_nettype wire

/* test/revo_generator_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module revo_generator_tb;
	import revo_pkg::*;

	localparam int MAX_TESTS = 32;
	localparam int CLOCK_PERIOD_NS = 4;
	localparam int TEST_MARGIN_CYCLES = 200;

	logic clock50;
	logic rst_n;
	bucket_cfg_t cfg;
	logic cfg_load;
	word_frame_t frame;
	logic [REVOLUTION_COUNT_W-1:0] revolution_count;
	logic [7:0] led;

	// one entry per test with the stimulus file fields
	logic [79:0] stimulus [0:MAX_TESTS-1];
	int num_tests;
	int total_words;
	longint watchdog_ns;
	logic watchdog_armed;

	int test_errors;
	int passed_tests;
	int failed_tests;

	revo_generator_top revo_generator_top_inst (
		.clock50          (clock50),
		.rst_n            (rst_n),
		.cfg              (cfg),
		.cfg_load         (cfg_load),
		.frame            (frame),
		.revolution_count (revolution_count),
		.led              (led)
	);

	initial clock50 = 1'b0;
	always #(CLOCK_PERIOD_NS / 2) clock50 = ~clock50;

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			$display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
			test_errors++;
		end
	endtask

	task automatic report_test(input string label);
		if (test_errors == 0) begin
			passed_tests++;
			$display("%s: ok", label);
		end else begin
			failed_tests++;
			$display("%s: failed with %0d errors", label, test_errors);
		end
	endtask

	// generator held idle right after reset
	task automatic check_power_up();
		test_errors = 0;
		repeat (2) @(negedge clock50);
		check_equal("frame", frame, 32'h0);
		// only the idle led is lit
		check_equal("led", led, 8'h04);
		report_test("power-up idle");
	endtask

	// strobe a new config, return at the negedge of its first output frame
	task automatic load_config(input bucket_cfg_t new_cfg);
		@(posedge clock50);
		cfg <= new_cfg;
		cfg_load <= 1'b1;
		@(posedge clock50);
		cfg_load <= 1'b0;
		// this edge registers the word at position 0
		@(posedge clock50);
		@(negedge clock50);
	endtask

	task automatic run_test(input int index);
		logic [79:0] entry;
		int period;
		int prescale;
		int words;
		int exp_markers;
		int exp_triggers;
		logic phase;
		bucket_cfg_t new_cfg;
		int markers;
		int triggers;
		int bit_index;
		int bucket;
		int last_bucket;
		int last_marker_word;
		logic is_trigger;
		logic [REVOLUTION_COUNT_W-1:0] start_count;
		logic [REVOLUTION_COUNT_W-1:0] count_delta;
		logic [7:0] expected_clock;
		logic [7:0] expected_revo;
		string label;

		entry = stimulus[index];
		period = entry[79:64];
		prescale = entry[63:56];
		phase = entry[48];
		words = entry[47:32];
		exp_markers = entry[31:16];
		exp_triggers = entry[15:0];

		test_errors = 0;
		markers = 0;
		triggers = 0;
		last_bucket = 0;
		last_marker_word = 0;
		new_cfg.period_buckets = 13'(period);
		new_cfg.prescale = 8'(prescale);
		new_cfg.clock_phase = phase;
		expected_clock = phase ? 8'h55 : 8'hAA;

		load_config(new_cfg);

		if (index == 0) begin
			// frames stay zero until run rises
			while (frame.revo_word[0] !== 1'b1) begin
				check_equal("frame", frame, 32'h0);
				@(negedge clock50);
			end
			check_equal("led[7]", led[7], 1'b1);
			check_equal("led[2]", led[2], 1'b0);
			// nothing was counted before run rose
			check_equal("revolution_count", revolution_count, 16'd1);
		end else begin
			// mid-run load restarts the revolution at bit 0
			check_equal("revo_word", frame.revo_word, 8'h01);
		end
		check_equal("led[6]", led[6], prescale != 0);

		// first frame already counted its own marker
		start_count = revolution_count - 16'd1;

		for (int w = 0; w < words; w++) begin
			if (w > 0) begin
				@(negedge clock50);
				// blink holds for the stretch time after the last marker
				check_equal("led[4]", led[4],
					(w - last_marker_word) <= LED_STRETCH_CYCLES + 1);
			end
			check_equal("led[5,3,1,0]", led & 8'h2B, 8'h00);

			// marker where the bucket index is a multiple of the period
			expected_revo = 8'h00;
			for (int k = 0; k < 8; k++) begin
				if ((w * 8 + k) % period == 0) begin
					expected_revo[k] = 1'b1;
				end
			end

			check_equal("clock_word", frame.clock_word, expected_clock);
			check_equal("revo_word", frame.revo_word, expected_revo);
			check_equal("revo", frame.revo, expected_revo != 8'h00);
			is_trigger = 1'b0;
			if (frame.revo_word != 8'h00) begin
				assert ($countones(frame.revo_word) == 1) else begin
					$display("mismatch revo_word: 0x%0h has more than one marker bit",
						frame.revo_word);
					test_errors++;
				end
				bit_index = 0;
				while (!frame.revo_word[bit_index]) begin
					bit_index++;
				end
				// absolute bucket since the load
				bucket = w * 8 + bit_index;
				if (markers == 0) begin
					check_equal("first marker bucket", bucket, 0);
				end else begin
					check_equal("marker spacing", bucket - last_bucket, period);
				end
				last_bucket = bucket;
				last_marker_word = w;
				markers++;
				is_trigger = (prescale != 0) && (markers % prescale == 0);
			end
			check_equal("trig_word", frame.trig_word, is_trigger ? expected_revo : 8'h00);
			if (frame.trig_word != 8'h00) begin
				triggers++;
			end
		end

		count_delta = revolution_count - start_count;
		check_equal("marker count", markers, exp_markers);
		check_equal("trigger count", triggers, exp_triggers);
		check_equal("revolution_count", count_delta, markers);

		label = $sformatf("test %0d period %0d prescale %0d phase %0d: %0d markers, %0d triggers",
			index, period, prescale, phase, markers, triggers);
		report_test(label);
	endtask

	initial begin
		rst_n = 1'b0;
		cfg = '0;
		cfg_load = 1'b0;
		watchdog_armed = 1'b0;
		num_tests = 0;
		total_words = 0;
		passed_tests = 0;
		failed_tests = 0;
		test_errors = 0;

		$readmemh("test/revo_stimulus.mem", stimulus);
		// list ends at the first unread or zero-period entry
		while (num_tests < MAX_TESTS && !$isunknown(stimulus[num_tests]) &&
				stimulus[num_tests][79:64] != 16'h0) begin
			total_words += stimulus[num_tests][47:32];
			num_tests++;
		end
		watchdog_ns = longint'(READY_DELAY + total_words + TEST_MARGIN_CYCLES * num_tests) *
			CLOCK_PERIOD_NS * 2;
		watchdog_armed = 1'b1;

		repeat (3) @(posedge clock50);
		rst_n <= 1'b1;

		if (num_tests == 0) begin
			$display("no tests were read from the stimulus file");
			failed_tests++;
		end

		check_power_up();
		for (int i = 0; i < num_tests; i++) begin
			run_test(i);
		end

		$display("tests run %0d, passed %0d, failed %0d",
			passed_tests + failed_tests, passed_tests, failed_tests);
		if (failed_tests == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// watchdog limit follows the total length of the tests
	initial begin
		wait (watchdog_armed);
		#(watchdog_ns);
		$display("timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/revo_stimulus.mem */
// period_prescale_phase_words_markers_triggers, all hex
// prescale 00 disables triggers, phase 00 selects AA and 01 selects 55
0010_01_00_0040_0020_0020
0011_03_01_0064_0030_0010
0018_00_00_005A_001E_0000
0064_02_01_00C8_0010_0008
1FFF_01_00_0028_0001_0001
0023_05_00_0096_0023_0007
0040_FF_01_0078_000F_0000
0013_04_01_004D_0021_0008
03E8_01_00_012C_0003_0003
0017_07_01_0080_002D_0006
0100_03_00_0100_0008_0002
001F_00_01_0032_000D_0000
0030_06_00_00B4_001E_0005
0010_02_01_0021_0011_0008
0FFF_01_01_044C_0003_0003
0081_09_00_00D2_000E_0001
0000_00_00_0000_0000_0000

/* sources.f */
design/revo_pkg.sv
design/reset_sequencer.sv
design/bucket_word_generator.sv
design/trigger_prescaler.sv
design/status_leds.sv
design/revo_generator_top.sv
test/revo_generator_tb.sv

/* Bender.yml */
package:
  name: revo_generator

sources:
  - files:
      - design/revo_pkg.sv
      - design/reset_sequencer.sv
      - design/bucket_word_generator.sv
      - design/trigger_prescaler.sv
      - design/status_leds.sv
      - design/revo_generator_top.sv

  - target: test
    files:
      - test/revo_generator_tb.sv
